//--- mem_disamb.f
+incdir+source
source/mem_disamb_pkg.sv
source/addr_gen_unit.sv
source/store_queue.sv
source/load_conflict_check.sv
source/mem_disamb.sv
sim/mem_disamb_props.sv
sim/tb_mem_disamb.sv

//--- sim/mem_disamb_props.sv
// memory disambiguation protocol checks
// bound to the top level, flags request and load result timing errors

`timescale 1ns/1ps

module mem_disamb_props (
  input logic clk,
  input logic rst,
  input logic req,
  input logic req_store,
  input logic stall,
  input logic load_valid
);

  // stores must be held off while the queue is full
  property no_store_on_stall;
    @(posedge clk) disable iff (rst)
      !(req && req_store && stall);
  endproperty

  // load result two edges after the request edge
  property load_latency;
    @(posedge clk) disable iff (rst)
      (req && !req_store) |-> ##2 load_valid;
  endproperty

  // outputs quiet on the first edge out of reset
  property quiet_after_reset;
    @(posedge clk)
      $fell(rst) |-> (!stall && !load_valid);
  endproperty

  a_no_store_on_stall : assert property (no_store_on_stall)
    else $error("store request while stall is high");

  a_load_latency : assert property (load_latency)
    else $error("load_valid did not follow a load request by two cycles");

  a_quiet_after_reset : assert property (quiet_after_reset)
    else $error("stall or load_valid high right after reset");

endmodule

bind mem_disamb mem_disamb_props u_props (
  .clk        (clk),
  .rst        (rst),
  .req        (req),
  .req_store  (req_store),
  .stall      (stall),
  .load_valid (load_valid)
);

//--- sim/tb_mem_disamb.sv
// memory disambiguation testbench
// directed tests of address generation, store queue back-pressure,
// commit order, flush and load conflict detection

`timescale 1ns/1ps

`include "mem_disamb_consts.svh"

module tb_mem_disamb;

  localparam int CLK_PERIOD  = 4;
  localparam int TEST_CYCLES = 4000;
  localparam int LOAD_WAIT   = 8;

  logic                  clk;
  logic                  rst;
  logic                  req;
  logic                  req_store;
  mem_disamb_pkg::addr_t base;
  mem_disamb_pkg::imm_t  imm;
  mem_disamb_pkg::size_t size;
  logic                  commit;
  logic                  flush;
  logic                  stall;
  logic                  load_valid;
  mem_disamb_pkg::addr_t load_addr;
  logic                  load_conflict;

  // pending stores, oldest first
  mem_disamb_pkg::addr_t model_addr [$];
  mem_disamb_pkg::size_t model_size [$];

  mem_disamb DUT (
    .clk           (clk),
    .rst           (rst),
    .req           (req),
    .req_store     (req_store),
    .base          (base),
    .imm           (imm),
    .size          (size),
    .commit        (commit),
    .flush         (flush),
    .stall         (stall),
    .load_valid    (load_valid),
    .load_addr     (load_addr),
    .load_conflict (load_conflict)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TEST_CYCLES * CLK_PERIOD);
    $display("watchdog expired before the tests completed");
    $display("Test failures found");
    $fatal(1, "timeout");
  end

  task automatic check_value(input string test, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("mismatch in %s: expected %0h, actual %0h", test, expected, actual);
      $display("Test failures found");
      $fatal(1, "stopped at first error");
    end
  endtask

  function automatic mem_disamb_pkg::addr_t effective_addr(input mem_disamb_pkg::addr_t b,
                                                           input mem_disamb_pkg::imm_t i);
    int off;
    off = i;
    return b + off;
  endfunction

  // half-open byte ranges, one bit wider so the end cannot wrap
  function automatic logic ranges_overlap(input mem_disamb_pkg::addr_t a,
                                          input mem_disamb_pkg::size_t a_sz,
                                          input mem_disamb_pkg::addr_t b,
                                          input mem_disamb_pkg::size_t b_sz);
    logic [`MD_ADDR_W:0] a_lo;
    logic [`MD_ADDR_W:0] a_hi;
    logic [`MD_ADDR_W:0] b_lo;
    logic [`MD_ADDR_W:0] b_hi;
    a_lo = {1'b0, a};
    a_hi = a_lo + ({{`MD_ADDR_W{1'b0}}, 1'b1} << a_sz);
    b_lo = {1'b0, b};
    b_hi = b_lo + ({{`MD_ADDR_W{1'b0}}, 1'b1} << b_sz);
    return (a_lo < b_hi) && (b_lo < a_hi);
  endfunction

  function automatic logic expected_conflict(input mem_disamb_pkg::addr_t a,
                                             input mem_disamb_pkg::size_t sz);
    logic hit;
    hit = 1'b0;
    for (int n = 0; n < model_addr.size(); n++) begin
      hit = hit | ranges_overlap(a, sz, model_addr[n], model_size[n]);
    end
    return hit;
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // one-cycle request strobe, entered and left on a falling edge
  task automatic drive_request(input logic store, input mem_disamb_pkg::addr_t b,
                               input mem_disamb_pkg::imm_t i,
                               input mem_disamb_pkg::size_t sz);
    req       = 1'b1;
    req_store = store;
    base      = b;
    imm       = i;
    size      = sz;
    @(negedge clk);
    req       = 1'b0;
    req_store = 1'b0;
  endtask

  task automatic run_load(input string test, input mem_disamb_pkg::addr_t b,
                          input mem_disamb_pkg::imm_t i, input mem_disamb_pkg::size_t sz);
    mem_disamb_pkg::addr_t exp_addr;
    logic                  exp_hit;
    int                    waited;
    exp_addr = effective_addr(b, i);
    exp_hit  = expected_conflict(exp_addr, sz);
    drive_request(1'b0, b, i, sz);
    // falling edges since the request edge, the first passed in drive_request
    waited = 1;
    do begin
      @(negedge clk);
      waited++;
    end while (!load_valid && waited < LOAD_WAIT);
    if (!load_valid) begin
      $display("no load result arrived in %s", test);
      $display("Test failures found");
      $fatal(1, "load result timeout");
    end
    // result is seen by the second rising edge after the request edge
    check_value(test, 2, waited);
    check_value(test, exp_addr, load_addr);
    check_value(test, exp_hit, load_conflict);
    idle_cycles(1);
  endtask

  task automatic issue_store(input mem_disamb_pkg::addr_t b, input mem_disamb_pkg::imm_t i,
                             input mem_disamb_pkg::size_t sz);
    drive_request(1'b1, b, i, sz);
    model_addr.push_back(effective_addr(b, i));
    model_size.push_back(sz);
    idle_cycles(2);
  endtask

  task automatic issue_commit();
    commit = 1'b1;
    @(negedge clk);
    commit = 1'b0;
    if (model_addr.size() > 0) begin
      void'(model_addr.pop_front());
      void'(model_size.pop_front());
    end
    idle_cycles(2);
  endtask

  task automatic issue_flush();
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    model_addr.delete();
    model_size.delete();
    idle_cycles(2);
  endtask

  task automatic address_calculation();
    mem_disamb_pkg::addr_t b;
    mem_disamb_pkg::imm_t  i;
    run_load("address_calc", 32'hFFFF_FFF0, 12'h7FF, 2'd2);
    run_load("address_calc", 32'h0000_0000, 12'hFFF, 2'd0);
    run_load("address_calc", 32'h0000_1000, 12'h800, 2'd3);
    for (int n = 0; n < 16; n++) begin
      b = $urandom();
      i = mem_disamb_pkg::imm_t'($urandom());
      // every other base sits in the top page
      if (n % 2 == 1) begin
        b = b | 32'hFFFF_F000;
      end
      run_load("address_calc", b, i, mem_disamb_pkg::size_t'($urandom()));
    end
  endtask

  task automatic overlap_detection();
    mem_disamb_pkg::addr_t st;
    int                    len_st;
    int                    len_ld;
    st = 32'h0000_2044;
    for (int ss = 0; ss < 4; ss++) begin
      len_st = 1 << ss;
      issue_store(st, '0, mem_disamb_pkg::size_t'(ss));
      for (int ls = 0; ls < 4; ls++) begin
        len_ld = 1 << ls;
        run_load("overlap", st, '0, mem_disamb_pkg::size_t'(ls));
        run_load("overlap", st, mem_disamb_pkg::imm_t'(len_st - 1), mem_disamb_pkg::size_t'(ls));
        run_load("overlap", st, mem_disamb_pkg::imm_t'(len_st), mem_disamb_pkg::size_t'(ls));
        run_load("overlap", st, mem_disamb_pkg::imm_t'(-len_ld), mem_disamb_pkg::size_t'(ls));
        run_load("overlap", st, mem_disamb_pkg::imm_t'(-1), mem_disamb_pkg::size_t'(ls));
        run_load("overlap", st, mem_disamb_pkg::imm_t'(16), mem_disamb_pkg::size_t'(ls));
      end
      issue_flush();
    end
  endtask

  task automatic full_queue_stall();
    for (int n = 0; n < `MD_SQ_DEPTH; n++) begin
      issue_store(32'h0000_3000 + mem_disamb_pkg::addr_t'(16 * n), '0, 2'd3);
    end
    check_value("full_queue", 1'b1, stall);
    issue_commit();
    check_value("full_queue", 1'b0, stall);
    issue_store(32'h0000_3100, '0, 2'd3);
    check_value("full_queue", 1'b1, stall);
    run_load("full_queue", 32'h0000_3000, '0, 2'd3);
    check_value("full_queue", 1'b0, load_conflict);
    run_load("full_queue", 32'h0000_3100, '0, 2'd3);
    check_value("full_queue", 1'b1, load_conflict);
    issue_flush();
    check_value("full_queue", 1'b0, stall);
  endtask

  task automatic commit_ordering();
    issue_store(32'h0000_4000, '0, 2'd2);
    issue_store(32'h0000_4100, '0, 2'd2);
    issue_commit();
    run_load("commit_order", 32'h0000_4000, '0, 2'd2);
    check_value("commit_order", 1'b0, load_conflict);
    run_load("commit_order", 32'h0000_4100, '0, 2'd2);
    check_value("commit_order", 1'b1, load_conflict);
    issue_flush();
  endtask

  task automatic flush_recovery();
    for (int n = 0; n < 5; n++) begin
      issue_store(32'h0000_5000 + mem_disamb_pkg::addr_t'(8 * n), '0, 2'd3);
    end
    run_load("flush", 32'h0000_5008, '0, 2'd3);
    check_value("flush", 1'b1, load_conflict);
    issue_flush();
    check_value("flush", 1'b0, stall);
    for (int n = 0; n < 5; n++) begin
      run_load("flush", 32'h0000_5000 + mem_disamb_pkg::addr_t'(8 * n), '0, 2'd3);
      check_value("flush", 1'b0, load_conflict);
    end
  endtask

  initial begin
    void'($urandom(12179));
    rst       = 1'b1;
    req       = 1'b0;
    req_store = 1'b0;
    base      = '0;
    imm       = '0;
    size      = '0;
    commit    = 1'b0;
    flush     = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    idle_cycles(1);
    check_value("reset", 1'b0, stall);
    check_value("reset", 1'b0, load_valid);
    check_value("reset", 0, load_addr);
    check_value("reset", 1'b0, load_conflict);
    address_calculation();
    overlap_detection();
    full_queue_stall();
    commit_ordering();
    flush_recovery();
    $display("All tests passed!");
    $finish;
  end

endmodule

//--- source/addr_gen_unit.sv
// address generation unit
// registers each load or store request and forms its effective
// address as base plus sign-extended immediate

`timescale 1ns/1ps

`include "mem_disamb_consts.svh"

module addr_gen_unit (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  req,
  input  logic                  req_store,
  input  mem_disamb_pkg::addr_t base,
  input  mem_disamb_pkg::imm_t  imm,
  input  mem_disamb_pkg::size_t size,
  output logic                  agu_valid,
  output logic                  agu_store,
  output mem_disamb_pkg::addr_t agu_addr,
  output mem_disamb_pkg::size_t agu_size
);

  mem_disamb_pkg::addr_t imm_ext;
  mem_disamb_pkg::addr_t eff_addr;

  // replicate the sign bit up to the address width
  assign imm_ext = {{(`MD_ADDR_W - `MD_IMM_W){imm[`MD_IMM_W-1]}}, imm};

  // wraps modulo 2^32
  assign eff_addr = base + imm_ext;

  // stage valid, one cycle per request
  always_ff @(posedge clk) begin
    if (rst) begin
      agu_valid <= 1'b0;
    end else begin
      agu_valid <= req;
    end
  end

  // stage payload, only meaningful with agu_valid
  always_ff @(posedge clk) begin
    if (req) begin
      agu_store <= req_store;
      agu_addr  <= eff_addr;
      agu_size  <= size;
    end
  end

endmodule

//--- source/load_conflict_check.sv
// load conflict checker
// compares the byte range of an agu-stage load against every valid
// store queue entry and registers the load address with the result

`timescale 1ns/1ps

`include "mem_disamb_consts.svh"

module load_conflict_check (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       agu_valid,
  input  logic                       agu_store,
  input  mem_disamb_pkg::addr_t      agu_addr,
  input  mem_disamb_pkg::size_t      agu_size,
  input  logic [`MD_SQ_DEPTH-1:0]    entry_valid,
  input  mem_disamb_pkg::addr_t      entry_addr [`MD_SQ_DEPTH],
  input  mem_disamb_pkg::size_t      entry_size [`MD_SQ_DEPTH],
  output logic                       load_valid,
  output mem_disamb_pkg::addr_t      load_addr,
  output logic                       load_conflict
);

  // access length in bytes, one bit wider than an address
  function automatic logic [`MD_ADDR_W:0] byte_span(input mem_disamb_pkg::size_t sz);
    logic [`MD_ADDR_W:0] span;
    span     = '0;
    span[sz] = 1'b1;
    return span;
  endfunction

  logic                   is_load;
  logic [`MD_ADDR_W:0]    ld_lo;
  logic [`MD_ADDR_W:0]    ld_hi;
  logic [`MD_SQ_DEPTH-1:0] hit;

  assign is_load = agu_valid && !agu_store;

  // extra top bit keeps the end from wrapping
  assign ld_lo = {1'b0, agu_addr};
  assign ld_hi = ld_lo + byte_span(agu_size);

  for (genvar i = 0; i < `MD_SQ_DEPTH; i++) begin : g_cmp
    logic [`MD_ADDR_W:0] st_lo;
    logic [`MD_ADDR_W:0] st_hi;

    assign st_lo = {1'b0, entry_addr[i]};
    assign st_hi = st_lo + byte_span(entry_size[i]);

    // half-open ranges overlap when each starts before the other ends
    assign hit[i] = entry_valid[i] && (ld_lo < st_hi) && (st_lo < ld_hi);
  end

  // load result register
  always_ff @(posedge clk) begin
    if (rst) begin
      load_valid    <= 1'b0;
      load_addr     <= '0;
      load_conflict <= 1'b0;
    end else begin
      load_valid <= is_load;
      if (is_load) begin
        load_addr     <= agu_addr;
        load_conflict <= |hit;
      end
    end
  end

endmodule

//--- source/mem_disamb.sv
// memory disambiguation top level
// address generation feeds a store queue and a load checker, which
// flags loads that overlap a pending store

`timescale 1ns/1ps

`include "mem_disamb_consts.svh"

module mem_disamb (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  req,
  input  logic                  req_store,
  input  mem_disamb_pkg::addr_t base,
  input  mem_disamb_pkg::imm_t  imm,
  input  mem_disamb_pkg::size_t size,
  input  logic                  commit,
  input  logic                  flush,
  output logic                  stall,
  output logic                  load_valid,
  output mem_disamb_pkg::addr_t load_addr,
  output logic                  load_conflict
);

  // agu stage
  logic                  agu_valid;
  logic                  agu_store;
  mem_disamb_pkg::addr_t agu_addr;
  mem_disamb_pkg::size_t agu_size;

  // queue contents
  logic [`MD_SQ_DEPTH-1:0] entry_valid;
  mem_disamb_pkg::addr_t   entry_addr [`MD_SQ_DEPTH];
  mem_disamb_pkg::size_t   entry_size [`MD_SQ_DEPTH];
  logic                    full;

  addr_gen_unit u_agu (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .req_store (req_store),
    .base      (base),
    .imm       (imm),
    .size      (size),
    .agu_valid (agu_valid),
    .agu_store (agu_store),
    .agu_addr  (agu_addr),
    .agu_size  (agu_size)
  );

  store_queue u_sq (
    .clk         (clk),
    .rst         (rst),
    .flush       (flush),
    .commit      (commit),
    .agu_valid   (agu_valid),
    .agu_store   (agu_store),
    .agu_addr    (agu_addr),
    .agu_size    (agu_size),
    .entry_valid (entry_valid),
    .entry_addr  (entry_addr),
    .entry_size  (entry_size),
    .full        (full)
  );

  load_conflict_check u_chk (
    .clk           (clk),
    .rst           (rst),
    .agu_valid     (agu_valid),
    .agu_store     (agu_store),
    .agu_addr      (agu_addr),
    .agu_size      (agu_size),
    .entry_valid   (entry_valid),
    .entry_addr    (entry_addr),
    .entry_size    (entry_size),
    .load_valid    (load_valid),
    .load_addr     (load_addr),
    .load_conflict (load_conflict)
  );

  // back-pressure toward the request source
  assign stall = full;

endmodule

//--- source/mem_disamb_consts.svh
// memory disambiguation constants
// widths of addresses, immediates and store queue indices

`ifndef MEM_DISAMB_CONSTS_SVH
`define MEM_DISAMB_CONSTS_SVH

// byte address width
`define MD_ADDR_W 32

// signed offset width of a request
`define MD_IMM_W 12

// store queue entries and index width
// depth must stay a power of two so the pointers wrap on their own
`define MD_SQ_DEPTH 8
`define MD_SQ_IDX_W 3

`endif

//--- source/mem_disamb_pkg.sv
// memory disambiguation types
// vector types for addresses, offsets, access sizes and queue indices

`include "mem_disamb_consts.svh"

package mem_disamb_pkg;

  // byte address
  typedef logic [`MD_ADDR_W-1:0] addr_t;

  // signed offset added to the base
  typedef logic signed [`MD_IMM_W-1:0] imm_t;

  // log2 of the access length, 0..3 for 1..8 bytes
  typedef logic [1:0] size_t;

  // store queue slot
  typedef logic [`MD_SQ_IDX_W-1:0] sq_idx_t;

  // occupancy, one bit wider so a full queue fits
  typedef logic [`MD_SQ_IDX_W:0] sq_cnt_t;

endpackage

//--- source/store_queue.sv
// store queue
// circular buffer of pending store addresses and sizes, filled from
// the agu stage, retired in order by commit and emptied by flush

`timescale 1ns/1ps

`include "mem_disamb_consts.svh"

module store_queue (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       flush,
  input  logic                       commit,
  input  logic                       agu_valid,
  input  logic                       agu_store,
  input  mem_disamb_pkg::addr_t      agu_addr,
  input  mem_disamb_pkg::size_t      agu_size,
  output logic [`MD_SQ_DEPTH-1:0]    entry_valid,
  output mem_disamb_pkg::addr_t      entry_addr [`MD_SQ_DEPTH],
  output mem_disamb_pkg::size_t      entry_size [`MD_SQ_DEPTH],
  output logic                       full
);

  mem_disamb_pkg::sq_idx_t head;
  mem_disamb_pkg::sq_idx_t tail;
  mem_disamb_pkg::sq_cnt_t count;

  logic push;
  logic pop;

  assign full = (count == `MD_SQ_DEPTH);

  // a store arriving while full is dropped
  assign push = agu_valid && agu_store && !full && !flush;

  // commit on an empty queue does nothing
  assign pop = commit && (count != '0) && !flush;

  // pointers, count and valid bits
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      head        <= '0;
      tail        <= '0;
      count       <= '0;
      entry_valid <= '0;
    end else begin
      if (push) begin
        entry_valid[tail] <= 1'b1;
        tail              <= tail + 1'b1;
      end

      // head and tail only meet when full or empty,
      // so push and pop never hit the same slot here
      if (pop) begin
        entry_valid[head] <= 1'b0;
        head              <= head + 1'b1;
      end

      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // entry payload
  always_ff @(posedge clk) begin
    if (push) begin
      entry_addr[tail] <= agu_addr;
      entry_size[tail] <= agu_size;
    end
  end

endmodule
